//--- hw/frontEndPkg.sv
package frontEndPkg;

  // Bundle and group widths.
  localparam int FETCH_WIDTH    = 8;
  localparam int DISPATCH_WIDTH = 4;

  // Circular queue geometry.
  localparam int QUEUE_DEPTH = 32;
  localparam int QUEUE_LOG   = 5;

  // Width of the group sequence tag.
  localparam int SEQ_WIDTH = 8;

  // Fetch is held off once more than this many entries wait.
  // Leaves room for two bundles already in flight.
  localparam int STALL_LIMIT = QUEUE_DEPTH - 2 * FETCH_WIDTH;

  // Counter widths for lane and group population counts.
  localparam int FETCH_CNT_W = $clog2(FETCH_WIDTH + 1);
  localparam int GRP_CNT_W   = $clog2(DISPATCH_WIDTH + 1);

  // Opcode class prefixes.
  localparam logic [3:0] OP_BRANCH_HI = 4'b0001;
  localparam logic [1:0] OP_LOAD_HI   = 2'b10;
  localparam logic [1:0] OP_STORE_HI  = 2'b11;

  // One decoded instruction of 73 bits.
  typedef struct packed {
    logic [31:0] pc;
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [15:0] imm;
    logic        isBranch;
    logic        isLoad;
    logic        isStore;
    logic        rdValid;
  } decodedInstT;

  // Raw fetch bundle as delivered by the fetch stage.
  typedef struct packed {
    logic [31:0]                  pc;
    logic [FETCH_WIDTH-1:0]       valid;
    logic [FETCH_WIDTH-1:0][31:0] inst;
  } fetchBundleT;

  // Registered output of decode.
  typedef struct packed {
    logic [FETCH_WIDTH-1:0]  valid;
    decodedInstT [FETCH_WIDTH-1:0] inst;
  } decodedBundleT;

  // Group handed to the back end.
  typedef struct packed {
    decodedInstT [DISPATCH_WIDTH-1:0] inst;
    logic [SEQ_WIDTH-1:0]             seq;
    logic [GRP_CNT_W-1:0]             branchCount;
    logic [GRP_CNT_W-1:0]             memCount;
  } dispatchGroupT;

endpackage

//--- hw/instDecode.sv
`timescale 1ns/1ns

module instDecode import frontEndPkg::*; (
  input  logic          clk,
  input  logic          rst_i,
  input  logic          flush_i,
  input  fetchBundleT   fetchBundle_i,
  input  logic          fetchValid_i,
  input  logic          stallFetch_i,
  output decodedBundleT decodedBundle_o,
  output logic          decodeValid_o
);

  // Decoded form of the bundle currently offered by fetch.
  decodedBundleT decodedNext;

  // A bundle is taken only while the buffer has room.
  logic accept;

  assign accept = fetchValid_i && !stallFetch_i;

  // Field extraction for every lane.
  always_comb begin : laneDecode
    logic [31:0] word;
    logic        branchBit;
    logic        storeBit;

    decodedNext.valid = fetchBundle_i.valid;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      word = fetchBundle_i.inst[k];
      // Lane pc steps by one word per lane.
      decodedNext.inst[k].pc     = fetchBundle_i.pc + 32'(k * 4);
      decodedNext.inst[k].opcode = word[31:26];
      decodedNext.inst[k].rd     = word[25:21];
      decodedNext.inst[k].rs1    = word[20:16];
      decodedNext.inst[k].rs2    = word[15:11];
      // Immediate overlaps rs2 on purpose.
      decodedNext.inst[k].imm    = word[15:0];

      // Class bits come from the opcode prefix alone.
      branchBit = (word[31:28] == OP_BRANCH_HI);
      storeBit  = (word[31:30] == OP_STORE_HI);
      decodedNext.inst[k].isBranch = branchBit;
      decodedNext.inst[k].isLoad   = (word[31:30] == OP_LOAD_HI);
      decodedNext.inst[k].isStore  = storeBit;
      // Branches and stores write no destination.
      decodedNext.inst[k].rdValid  = !(branchBit || storeBit);
    end
  end

  // Pipeline register between fetch and the buffer.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      decodeValid_o         <= 1'b0;
      decodedBundle_o.valid <= '0;
    end else if (accept) begin
      decodeValid_o   <= 1'b1;
      decodedBundle_o <= decodedNext;
    end else begin
      // Bubble cycle clears only the mask.
      decodeValid_o         <= 1'b0;
      decodedBundle_o.valid <= '0;
    end
  end

  // The buffer writes on the mask, so a bubble must never carry live lanes.
  assert property (@(posedge clk) disable iff (rst_i)
    !decodeValid_o |-> (decodedBundle_o.valid == '0))
    else $error("instDecode: lanes valid without decodeValid");

endmodule

//--- hw/instQueueRam.sv
`timescale 1ns/1ns

module instQueueRam import frontEndPkg::*; (
  input  logic                                      clk,
  input  logic [FETCH_WIDTH-1:0]                    weVec_i,
  input  logic [FETCH_WIDTH-1:0][QUEUE_LOG-1:0]     wrAddr_i,
  input  decodedInstT [FETCH_WIDTH-1:0]             wrData_i,
  input  logic [DISPATCH_WIDTH-1:0][QUEUE_LOG-1:0]  rdAddr_i,
  output decodedInstT [DISPATCH_WIDTH-1:0]          rdData_o
);

  // Queue storage.
  decodedInstT mem [QUEUE_DEPTH];

  // Set when two enabled write ports target one entry.
  logic wrConflict;

  // Eight write ports share one edge.
  always_ff @(posedge clk) begin
    for (int p = 0; p < FETCH_WIDTH; p++) begin
      if (weVec_i[p]) begin
        mem[wrAddr_i[p]] <= wrData_i[p];
      end
    end
  end

  // Four asynchronous read ports.
  for (genvar r = 0; r < DISPATCH_WIDTH; r++) begin : gRead
    assign rdData_o[r] = mem[rdAddr_i[r]];
  end

  // Pairwise compare of the write addresses.
  always_comb begin
    wrConflict = 1'b0;
    for (int a = 0; a < FETCH_WIDTH; a++) begin
      for (int b = a + 1; b < FETCH_WIDTH; b++) begin
        if (weVec_i[a] && weVec_i[b] && (wrAddr_i[a] == wrAddr_i[b])) begin
          wrConflict = 1'b1;
        end
      end
    end
  end

  // Lane packing in the buffer must hand out distinct entries.
  assert property (@(posedge clk) !wrConflict)
    else $error("instQueueRam: two write ports hit one entry");

endmodule

//--- hw/instBuffer.sv
`timescale 1ns/1ns

module instBuffer import frontEndPkg::*; (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             flush_i,
  input  logic                             stall_i,
  input  decodedBundleT                    decodedBundle_i,
  input  logic                             decodeValid_i,
  output logic                             stallFetch_o,
  output logic                             release_o,
  output decodedInstT [DISPATCH_WIDTH-1:0] group_o
);

  // Queue pointers and occupancy.
  logic [QUEUE_LOG-1:0] headPtr;
  logic [QUEUE_LOG-1:0] tailPtr;
  logic [QUEUE_LOG:0]   count;
  logic [QUEUE_LOG:0]   countNext;

  // Write side.
  logic [FETCH_WIDTH-1:0]                  weVec;
  logic [FETCH_WIDTH-1:0][QUEUE_LOG-1:0]   wrAddr;
  logic [FETCH_WIDTH-1:0][FETCH_CNT_W-1:0] laneOffset;
  logic [FETCH_CNT_W-1:0]                  writeCount;

  // Read side.
  logic [DISPATCH_WIDTH-1:0][QUEUE_LOG-1:0] rdAddr;

  // Every valid lane of a decoded bundle is written.
  // Room is guaranteed by the fetch stall threshold.
  assign weVec = decodedBundle_i.valid & {FETCH_WIDTH{decodeValid_i}};

  // Prefix count of valid lanes below each lane.
  always_comb begin
    laneOffset[0] = '0;
    for (int k = 1; k < FETCH_WIDTH; k++) begin
      laneOffset[k] = laneOffset[k-1] + FETCH_CNT_W'(weVec[k-1]);
    end
    writeCount = laneOffset[FETCH_WIDTH-1] + FETCH_CNT_W'(weVec[FETCH_WIDTH-1]);
  end

  // Valid lanes land back to back from the tail.
  for (genvar k = 0; k < FETCH_WIDTH; k++) begin : gWrAddr
    assign wrAddr[k] = tailPtr + QUEUE_LOG'(laneOffset[k]);
  end

  // Group is read straight from the head.
  for (genvar r = 0; r < DISPATCH_WIDTH; r++) begin : gRdAddr
    assign rdAddr[r] = headPtr + QUEUE_LOG'(r);
  end

  instQueueRam ram_i (
    .clk      (clk),
    .weVec_i  (weVec),
    .wrAddr_i (wrAddr),
    .wrData_i (decodedBundle_i.inst),
    .rdAddr_i (rdAddr),
    .rdData_o (group_o)
  );

  // Release a full group unless the back end stalls.
  assign release_o = (count >= (QUEUE_LOG+1)'(DISPATCH_WIDTH)) && !stall_i;

  // Hold fetch off while two more bundles might not fit.
  assign stallFetch_o = (count > (QUEUE_LOG+1)'(STALL_LIMIT));

  // Occupancy after this edge's write and release.
  always_comb begin
    countNext = count + (QUEUE_LOG+1)'(writeCount);
    if (release_o) begin
      countNext = countNext - (QUEUE_LOG+1)'(DISPATCH_WIDTH);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else begin
      // Pointers wrap naturally at QUEUE_DEPTH.
      tailPtr <= tailPtr + QUEUE_LOG'(writeCount);
      if (release_o) begin
        headPtr <= headPtr + QUEUE_LOG'(DISPATCH_WIDTH);
      end
      count <= countNext;
    end
  end

  // Decode honours the fetch stall, so the queue never overflows.
  assert property (@(posedge clk) disable iff (rst_i)
    count <= (QUEUE_LOG+1)'(QUEUE_DEPTH))
    else $error("instBuffer: queue overflow");

  // The entries between head and tail cover every released group.
  // A full queue has head and tail equal.
  assert property (@(posedge clk) disable iff (rst_i)
    release_o |-> ((count == (QUEUE_LOG+1)'(QUEUE_DEPTH)) ||
                   (QUEUE_LOG'(tailPtr - headPtr) >= QUEUE_LOG'(DISPATCH_WIDTH))))
    else $error("instBuffer: release below group size");

endmodule

//--- hw/dispatchGroup.sv
`timescale 1ns/1ns

module dispatchGroup import frontEndPkg::*; (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             flush_i,
  input  logic                             release_i,
  input  decodedInstT [DISPATCH_WIDTH-1:0] group_i,
  output dispatchGroupT                    dispatchGroup_o,
  output logic                             dispatchValid_o
);

  // Tag given to the next group.
  logic [SEQ_WIDTH-1:0] seqTag;

  // Class counts of the group at the head.
  logic [GRP_CNT_W-1:0] branchSum;
  logic [GRP_CNT_W-1:0] memSum;

  // Branches and memory ops among the four packets.
  always_comb begin
    branchSum = '0;
    memSum    = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      branchSum = branchSum + GRP_CNT_W'(group_i[i].isBranch);
      memSum    = memSum + GRP_CNT_W'(group_i[i].isLoad | group_i[i].isStore);
    end
  end

  // Control state.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      dispatchValid_o <= 1'b0;
      seqTag          <= '0;
    end else begin
      // One pulse per released group.
      dispatchValid_o <= release_i;
      if (release_i) begin
        // wraps at SEQ_WIDTH bits
        seqTag <= seqTag + SEQ_WIDTH'(1);
      end
    end
  end

  // Group payload.
  // Only meaningful while dispatchValid_o is high.
  always_ff @(posedge clk) begin
    if (release_i) begin
      dispatchGroup_o.inst        <= group_i;
      dispatchGroup_o.seq         <= seqTag;
      dispatchGroup_o.branchCount <= branchSum;
      dispatchGroup_o.memCount    <= memSum;
    end
  end

  // Decode makes branch and memory classes exclusive.
  assert property (@(posedge clk) disable iff (rst_i)
    dispatchValid_o |->
      ((GRP_CNT_W+1)'(dispatchGroup_o.branchCount) +
       (GRP_CNT_W+1)'(dispatchGroup_o.memCount)) <= (GRP_CNT_W+1)'(DISPATCH_WIDTH))
    else $error("dispatchGroup: class counts exceed group size");

endmodule

//--- hw/frontEndTop.sv
`timescale 1ns/1ns

module frontEndTop import frontEndPkg::*; (
  input  logic          clk,
  input  logic          rst_i,
  input  logic          flush_i,
  input  logic          stall_i,
  input  fetchBundleT   fetchBundle_i,
  input  logic          fetchValid_i,
  output logic          stallFetch_o,
  output dispatchGroupT dispatchGroup_o,
  output logic          dispatchValid_o
);

  // Decode to buffer.
  decodedBundleT decodedBundle;
  logic          decodeValid;

  // Buffer to dispatch group.
  logic                             releaseGrp;
  decodedInstT [DISPATCH_WIDTH-1:0] group;

  // Fetch stall raised by the buffer occupancy.
  logic stallFetch;

  assign stallFetch_o = stallFetch;

  instDecode decode_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .fetchBundle_i   (fetchBundle_i),
    .fetchValid_i    (fetchValid_i),
    .stallFetch_i    (stallFetch),
    .decodedBundle_o (decodedBundle),
    .decodeValid_o   (decodeValid)
  );

  instBuffer buffer_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .stall_i         (stall_i),
    .decodedBundle_i (decodedBundle),
    .decodeValid_i   (decodeValid),
    .stallFetch_o    (stallFetch),
    .release_o       (releaseGrp),
    .group_o         (group)
  );

  // Result stage.
  dispatchGroup dispatch_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .release_i       (releaseGrp),
    .group_i         (group),
    .dispatchGroup_o (dispatchGroup_o),
    .dispatchValid_o (dispatchValid_o)
  );

endmodule

//--- bench/frontEndTb.sv
`timescale 1ns/1ns

module frontEndTb import frontEndPkg::*; ();

  // One stimulus row, applied for a number of cycles.
  typedef struct packed {
    logic [31:0] pc;
    logic [7:0]  mask;
    logic        stall;
    logic        flush;
    logic [7:0]  cycles;
  } stimRowT;

  localparam int NUM_ROWS      = 10;
  localparam int DRAIN_TIMEOUT = 60;

  // Full bundles, sparse masks, lone lanes, back-end stall, then a flush.
  stimRowT stimRows [NUM_ROWS] = '{
    '{32'h0000_1000, 8'hff, 1'b0, 1'b0, 8'd6},
    '{32'h0000_2000, 8'ha5, 1'b0, 1'b0, 8'd8},
    '{32'h0000_3000, 8'h01, 1'b0, 1'b0, 8'd10},
    '{32'h0000_4000, 8'h00, 1'b0, 1'b0, 8'd6},
    '{32'h0000_5000, 8'h49, 1'b0, 1'b0, 8'd3},
    '{32'h0000_6000, 8'hff, 1'b1, 1'b0, 8'd12},
    '{32'h0000_7000, 8'h3c, 1'b0, 1'b0, 8'd12},
    '{32'h0000_8000, 8'hf0, 1'b1, 1'b0, 8'd4},
    '{32'h0000_9000, 8'h5a, 1'b0, 1'b1, 8'd10},
    '{32'h0000_a000, 8'h00, 1'b0, 1'b0, 8'd4}
  };

  logic          clk;
  logic          rst_i;
  logic          flush_i;
  logic          stall_i;
  fetchBundleT   fetchBundle_i;
  logic          fetchValid_i;
  logic          stallFetch_o;
  dispatchGroupT dispatchGroup_o;
  logic          dispatchValid_o;

  // Random source for instruction words.
  logic [31:0] lfsrState = 32'h0ad2_fd73;

  // Fetch side state.
  // A bundle is held until it is taken.
  fetchBundleT heldBundle;
  logic        holding = 1'b0;
  int          bundleNum = 0;

  // Reference model of every accepted instruction not yet dispatched.
  decodedInstT expQueue[$];
  // Buffer occupancy and lanes still sitting in the decode register.
  int          expCount = 0;
  int          inflight = 0;
  // Inputs driven for the coming edge.
  logic        lastStall = 1'b0;
  logic        lastFlush = 1'b0;
  logic        lastAccept = 1'b0;
  int          lastLanes = 0;
  logic [SEQ_WIDTH-1:0] expSeq = '0;
  int          groupsSeen = 0;
  logic        sawFetchStall = 1'b0;

  frontEndTop dut_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .stall_i         (stall_i),
    .fetchBundle_i   (fetchBundle_i),
    .fetchValid_i    (fetchValid_i),
    .stallFetch_o    (stallFetch_o),
    .dispatchGroup_o (dispatchGroup_o),
    .dispatchValid_o (dispatchValid_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      lfsrNext = (s >> 1) ^ 32'h8020_0003;
    end else begin
      lfsrNext = s >> 1;
    end
  endfunction

  // One step per bit taken.
  task automatic randomWord(output logic [31:0] w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // Expected decode of one lane.
  function automatic decodedInstT predictInst(input logic [31:0] pc, input logic [31:0] w);
    decodedInstT d;
    d.pc       = pc;
    d.opcode   = w[31:26];
    d.rd       = w[25:21];
    d.rs1      = w[20:16];
    d.rs2      = w[15:11];
    d.imm      = w[15:0];
    d.isBranch = (w[31:28] == OP_BRANCH_HI);
    d.isLoad   = (w[31:30] == OP_LOAD_HI);
    d.isStore  = (w[31:30] == OP_STORE_HI);
    // Only branches and stores lack a destination.
    d.rdValid  = !(d.isBranch || d.isStore);
    return d;
  endfunction

  task automatic checkValue(input string testName, input logic [79:0] expVal,
                            input logic [79:0] actVal);
    if (expVal !== actVal) begin
      $display("[ERROR] %s expected %h actual %h", testName, expVal, actVal);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Updates the model for the edge just passed and checks the outputs.
  task automatic scoreEdge();
    logic        expRelease;
    decodedInstT expInst;
    int          branchExp;
    int          memExp;
    if (lastFlush) begin
      expRelease = 1'b0;
      expCount   = 0;
      inflight   = 0;
      expSeq     = '0;
    end else begin
      // Release uses the count before this edge's write.
      expRelease = (expCount >= DISPATCH_WIDTH) && !lastStall;
      expCount   = expCount + inflight - (expRelease ? DISPATCH_WIDTH : 0);
      inflight   = lastAccept ? lastLanes : 0;
    end
    checkValue("dispatchValid_o", 80'(expRelease), 80'(dispatchValid_o));
    checkValue("stallFetch_o", 80'(expCount > QUEUE_DEPTH - 2 * FETCH_WIDTH), 80'(stallFetch_o));
    if (stallFetch_o) begin
      sawFetchStall = 1'b1;
    end
    if (dispatchValid_o) begin
      checkValue("four waiting at dispatch", 80'(1), 80'(expQueue.size() >= DISPATCH_WIDTH));
      branchExp = 0;
      memExp    = 0;
      // Slot 0 holds the oldest instruction.
      for (int s = 0; s < DISPATCH_WIDTH; s++) begin
        expInst = expQueue.pop_front();
        checkValue($sformatf("group %0d slot %0d", groupsSeen, s),
                   80'(expInst), 80'(dispatchGroup_o.inst[s]));
        branchExp += int'(expInst.isBranch);
        memExp    += int'(expInst.isLoad || expInst.isStore);
      end
      checkValue("group seq", 80'(expSeq), 80'(dispatchGroup_o.seq));
      checkValue("branchCount", 80'(branchExp), 80'(dispatchGroup_o.branchCount));
      checkValue("memCount", 80'(memExp), 80'(dispatchGroup_o.memCount));
      expSeq = expSeq + SEQ_WIDTH'(1);
      groupsSeen++;
    end
  endtask

  // Drives one cycle on the falling edge, then checks after the rising edge.
  task automatic runCycle(input logic [7:0] mask, input logic [31:0] basePc,
                          input logic stallLvl, input logic doFlush);
    logic [31:0] word;
    if (!holding && mask != 8'h00 && !doFlush) begin
      heldBundle.pc    = basePc + 32'(32 * bundleNum);
      heldBundle.valid = mask;
      // Unused lanes also get random words.
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        randomWord(word);
        heldBundle.inst[k] = word;
      end
      bundleNum++;
      holding = 1'b1;
    end
    fetchBundle_i = heldBundle;
    fetchValid_i  = holding;
    stall_i       = stallLvl;
    flush_i       = doFlush;
    lastStall     = stallLvl;
    lastFlush     = doFlush;
    // Fetch is held off while the model count is above the threshold.
    lastAccept    = holding && (expCount <= QUEUE_DEPTH - 2 * FETCH_WIDTH) && !doFlush;
    lastLanes     = $countones(heldBundle.valid);
    if (lastAccept) begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        if (heldBundle.valid[k]) begin
          expQueue.push_back(predictInst(heldBundle.pc + 32'(4 * k), heldBundle.inst[k]));
        end
      end
      holding = 1'b0;
    end
    if (doFlush) begin
      // The offered bundle is dropped along with everything queued.
      expQueue.delete();
      holding = 1'b0;
    end
    @(posedge clk);
    @(negedge clk);
    scoreEdge();
  endtask

  initial begin
    int drainCycles;
    rst_i         = 1'b1;
    flush_i       = 1'b0;
    stall_i       = 1'b0;
    fetchValid_i  = 1'b0;
    fetchBundle_i = '0;
    heldBundle    = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    checkValue("dispatchValid_o after reset", 80'(0), 80'(dispatchValid_o));
    checkValue("stallFetch_o after reset", 80'(0), 80'(stallFetch_o));

    for (int r = 0; r < NUM_ROWS; r++) begin
      bundleNum = 0;
      for (int c = 0; c < int'(stimRows[r].cycles); c++) begin
        // Flush lasts one cycle at the start of its row.
        runCycle(stimRows[r].mask, stimRows[r].pc, stimRows[r].stall,
                 stimRows[r].flush && (c == 0));
      end
    end

    // Let every full group leave.
    drainCycles = 0;
    while (holding || inflight != 0 || expCount >= DISPATCH_WIDTH) begin
      if (drainCycles == DRAIN_TIMEOUT) begin
        $display("STATUS: FAIL");
        $fatal(1, "timeout: queue did not drain within %0d cycles", DRAIN_TIMEOUT);
      end
      runCycle(8'h00, 32'h0, 1'b0, 1'b0);
      drainCycles++;
    end

    checkValue("fetch stall seen", 80'(1), 80'(sawFetchStall));
    checkValue("groups dispatched", 80'(1), 80'(groupsSeen > 0));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- frontEnd.f
hw/frontEndPkg.sv
hw/instDecode.sv
hw/instQueueRam.sv
hw/instBuffer.sv
hw/dispatchGroup.sv
hw/frontEndTop.sv
bench/frontEndTb.sv

//--- run.sh
#!/bin/sh
# Build the front end testbench with Verilator and run it.
# A $fatal in the testbench gives a nonzero exit status.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module frontEndTb \
  -f frontEnd.f -Mdir obj_dir -o frontEndSim &&
./obj_dir/frontEndSim ||
{ echo "front end simulation failed"; exit 1; }
